/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_core_tb
LINT_TOP  ?= rv_core
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  := *** TEST PASSED ***

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rv_core.f */
src/rv_isa_pkg.sv
src/rv_core_pkg.sv
src/rv_regfile.sv
src/rv_decode_stage.sv
src/rv_execute_stage.sv
src/rv_pipe_ctrl.sv
src/rv_core.sv
test/rv_core_tb.sv

/* src/rv_core.sv */
`timescale 1ns/100ps

module rv_core #(
    parameter int REG_COUNT = 32                // 32 for rv32i, 16 for rv32e
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instr_valid,
    input  rv_isa_pkg::word_t    instr,
    output logic                 wb_valid,
    output rv_isa_pkg::reg_idx_t wb_rd,
    output rv_isa_pkg::word_t    wb_data,
    output logic                 halt
);

    logic                  accept;
    logic                  illegal;
    logic                  ex_valid;
    rv_core_pkg::dec_t     dec_q;
    rv_core_pkg::wb_t      wb_q;
    rv_core_pkg::fwd_sel_e fwd_a;
    rv_core_pkg::fwd_sel_e fwd_b;
    rv_isa_pkg::word_t     rd1;
    rv_isa_pkg::word_t     rd2;

    assign wb_rd   = wb_q.rd;
    assign wb_data = wb_q.data;

    rv_pipe_ctrl ctrl_i (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .illegal(illegal),
        .dec_q(dec_q), .wb_q(wb_q), .accept(accept), .ex_valid(ex_valid),
        .wb_valid(wb_valid), .halt(halt), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    rv_decode_stage #(.REG_COUNT(REG_COUNT)) dec_i (
        .clk(clk), .rst(rst), .accept(accept), .instr(instr),
        .illegal(illegal), .dec_q(dec_q)
    );

    rv_regfile #(.REG_COUNT(REG_COUNT)) rf_i (
        .clk(clk), .rst(rst), .rs1(dec_q.rs1), .rs2(dec_q.rs2),
        .rd1(rd1), .rd2(rd2), .we(wb_valid), .wr(wb_q)
    );

    rv_execute_stage ex_i (
        .clk(clk), .rst(rst), .ex_valid(ex_valid), .dec_q(dec_q),
        .rd1(rd1), .rd2(rd2), .fwd_a(fwd_a), .fwd_b(fwd_b), .wb_q(wb_q)
    );

endmodule

/* src/rv_core_pkg.sv */
package rv_core_pkg;

    // ALU operations
    // encoding is internal to the core and does not follow funct3
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,              // signed compare
        SLTU   = 4'd4,              // unsigned compare
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10              // lui, result is operand b
    } alu_op_e;

    // operand source in execute
    typedef enum logic {
        FWD_RF = 1'b0,              // register file read port
        FWD_WB = 1'b1               // result held in write-back register
    } fwd_sel_e;

    // decoded instruction, decode to execute
    typedef struct packed {
        alu_op_e              alu_op;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        rv_isa_pkg::reg_idx_t rd;
        logic                 use_imm;  // operand b from imm
        rv_isa_pkg::word_t    imm;      // I- or U-immediate
        logic                 use_rs1;  // low for lui, operand a is zero
    } dec_t;

    // result, execute to write-back
    typedef struct packed {
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::word_t    data;
    } wb_t;

    // pipeline overview
    // decode   loads dec_q at the edge that samples the strobe
    // execute  loads wb_q one edge later
    // wb_q drives the outputs and writes the register file at the next edge
    //
    // an instruction one slot behind its producer sees the result in wb_q,
    // later ones find it already in the register file

endpackage

/* src/rv_decode_stage.sv */
`timescale 1ns/100ps

module rv_decode_stage #(
    parameter int REG_COUNT = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              accept,
    input  rv_isa_pkg::word_t instr,
    output logic              illegal,
    output rv_core_pkg::dec_t dec_q
);

    rv_isa_pkg::opcode_e  opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    rv_isa_pkg::reg_idx_t rs1;
    rv_isa_pkg::reg_idx_t rs2;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::word_t    imm_i;
    rv_isa_pkg::word_t    imm_u;
    logic                 is_op;
    logic                 is_imm;
    logic                 is_lui;
    logic                 f7_base;
    logic                 f7_alt;
    logic                 bad_f7;
    logic                 bad_reg;
    rv_core_pkg::alu_op_e alu_op;
    rv_core_pkg::dec_t    dec_d;

    // field split
    assign opcode = rv_isa_pkg::opcode_e'(instr[6:0]);
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]}; // sign extended
    assign imm_u = {instr[31:12], 12'b0};

    assign is_op   = (opcode == rv_isa_pkg::OP);
    assign is_imm  = (opcode == rv_isa_pkg::OP_IMM);
    assign is_lui  = (opcode == rv_isa_pkg::LUI);
    assign f7_base = (funct7 == rv_isa_pkg::F7_BASE);
    assign f7_alt  = (funct7 == rv_isa_pkg::F7_ALT);

    // funct7 only matters for R-type and the shift immediates
    always_comb begin
        bad_f7 = 1'b0;
        if (is_op) begin
            bad_f7 = !(f7_base || (f7_alt && (funct3 == rv_isa_pkg::F3_ADD ||
                                              funct3 == rv_isa_pkg::F3_SR)));
        end else if (is_imm && funct3 == rv_isa_pkg::F3_SLL) begin
            bad_f7 = !f7_base;                   // slli upper bits must be zero
        end else if (is_imm && funct3 == rv_isa_pkg::F3_SR) begin
            bad_f7 = !(f7_base || f7_alt);       // srli or srai
        end
    end

    // rv32e has only 16 registers
    assign bad_reg = (rd >= REG_COUNT) ||
                     ((is_op || is_imm) && rs1 >= REG_COUNT) ||
                     (is_op && rs2 >= REG_COUNT);

    assign illegal = !(is_op || is_imm || is_lui) ||
                     bad_f7 ||
                     (is_imm && funct3 == rv_isa_pkg::F3_SLTU) || // no sltiu
                     bad_reg;

    always_comb begin
        alu_op = rv_core_pkg::ADD;
        case (funct3)
            rv_isa_pkg::F3_ADD:  alu_op = (is_op && f7_alt) ? rv_core_pkg::SUB : rv_core_pkg::ADD;
            rv_isa_pkg::F3_SLL:  alu_op = rv_core_pkg::SLL;
            rv_isa_pkg::F3_SLT:  alu_op = rv_core_pkg::SLT;
            rv_isa_pkg::F3_SLTU: alu_op = rv_core_pkg::SLTU;
            rv_isa_pkg::F3_XOR:  alu_op = rv_core_pkg::XOR;
            rv_isa_pkg::F3_SR:   alu_op = f7_alt ? rv_core_pkg::SRA : rv_core_pkg::SRL;
            rv_isa_pkg::F3_OR:   alu_op = rv_core_pkg::OR;
            rv_isa_pkg::F3_AND:  alu_op = rv_core_pkg::AND;
        endcase
        if (is_lui) begin
            alu_op = rv_core_pkg::PASS_B;
        end
    end

    always_comb begin
        dec_d.alu_op  = alu_op;
        dec_d.rs1     = rs1;
        dec_d.rs2     = rs2;
        dec_d.rd      = rd;
        dec_d.use_imm = !is_op;                  // op_imm and lui
        dec_d.imm     = is_lui ? imm_u : imm_i;
        dec_d.use_rs1 = !is_lui;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            dec_q <= '0;
        end else if (accept) begin
            dec_q <= dec_d;
        end
    end

endmodule

/* src/rv_execute_stage.sv */
`timescale 1ns/100ps

module rv_execute_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ex_valid,
    input  rv_core_pkg::dec_t     dec_q,
    input  rv_isa_pkg::word_t     rd1,
    input  rv_isa_pkg::word_t     rd2,
    input  rv_core_pkg::fwd_sel_e fwd_a,
    input  rv_core_pkg::fwd_sel_e fwd_b,
    output rv_core_pkg::wb_t      wb_q
);

    rv_isa_pkg::word_t  src_a;
    rv_isa_pkg::word_t  src_b;
    rv_isa_pkg::word_t  op_a;
    rv_isa_pkg::word_t  op_b;
    rv_isa_pkg::shamt_t shamt;
    rv_isa_pkg::word_t  result;

    // forwarding mux, previous result or register file
    assign src_a = (fwd_a == rv_core_pkg::FWD_WB) ? wb_q.data : rd1;
    assign src_b = (fwd_b == rv_core_pkg::FWD_WB) ? wb_q.data : rd2;

    assign op_a  = dec_q.use_rs1 ? src_a : '0;   // zero for lui
    assign op_b  = dec_q.use_imm ? dec_q.imm : src_b;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec_q.alu_op)
            rv_core_pkg::ADD:    result = op_a + op_b;
            rv_core_pkg::SUB:    result = op_a - op_b;
            rv_core_pkg::SLL:    result = op_a << shamt;
            rv_core_pkg::SLT:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_core_pkg::SLTU:   result = {31'b0, op_a < op_b};
            rv_core_pkg::XOR:    result = op_a ^ op_b;
            rv_core_pkg::SRL:    result = op_a >> shamt;
            rv_core_pkg::SRA:    result = $signed(op_a) >>> shamt; // sign fill
            rv_core_pkg::OR:     result = op_a | op_b;
            rv_core_pkg::AND:    result = op_a & op_b;
            rv_core_pkg::PASS_B: result = op_b;
            default:             result = op_b;
        endcase
    end

    // write-back register
    // also the forwarding source for the next instruction
    always_ff @(posedge clk) begin
        if (!rst) begin
            wb_q <= '0;
        end else if (ex_valid) begin
            wb_q.rd   <= dec_q.rd;
            wb_q.data <= result;
        end
    end

endmodule

/* src/rv_isa_pkg.sv */
package rv_isa_pkg;

    // architectural widths
    typedef logic [31:0] word_t;    // data word
    typedef logic [4:0]  reg_idx_t; // x0..x31
    typedef logic [4:0]  shamt_t;   // shift amount, low five bits

    // major opcodes still handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,        // register-register arithmetic
        OP_IMM = 7'b0010011,        // register-immediate arithmetic
        LUI    = 7'b0110111         // load upper immediate
    } opcode_e;

    // funct3 field
    // the same codes are shared by the register and immediate forms
    localparam logic [2:0] F3_ADD  = 3'b000; // add, sub, addi
    localparam logic [2:0] F3_SLL  = 3'b001; // sll, slli
    localparam logic [2:0] F3_SLT  = 3'b010; // slt, slti
    localparam logic [2:0] F3_SLTU = 3'b011; // sltu only, no immediate form here
    localparam logic [2:0] F3_XOR  = 3'b100; // xor, xori
    localparam logic [2:0] F3_SR   = 3'b101; // srl, sra and immediate forms
    localparam logic [2:0] F3_OR   = 3'b110; // or, ori
    localparam logic [2:0] F3_AND  = 3'b111; // and, andi

    // funct7 field
    localparam logic [6:0] F7_BASE = 7'b0000000; // normal form
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub and arithmetic shift

    // instruction field positions
    // opcode   [6:0]
    // rd       [11:7]
    // funct3   [14:12]
    // rs1      [19:15]
    // rs2      [24:20], also shamt for shift immediates
    // funct7   [31:25]
    // I-imm    [31:20], sign extended
    // U-imm    [31:12], low twelve bits zero

endpackage

/* src/rv_pipe_ctrl.sv */
`timescale 1ns/100ps

module rv_pipe_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,
    input  logic                  illegal,
    input  rv_core_pkg::dec_t     dec_q,
    input  rv_core_pkg::wb_t      wb_q,
    output logic                  accept,
    output logic                  ex_valid,
    output logic                  wb_valid,
    output logic                  halt,
    output rv_core_pkg::fwd_sel_e fwd_a,
    output rv_core_pkg::fwd_sel_e fwd_b
);

    rv_isa_pkg::reg_idx_t wb_rd;
    logic                 wb_live;

    // strobes are dropped once halted
    assign accept = instr_valid && !halt;

    always_ff @(posedge clk) begin
        if (!rst) begin
            ex_valid <= 1'b0;
            wb_valid <= 1'b0;
            halt     <= 1'b0;
        end else begin
            ex_valid <= accept && !illegal;     // illegal one never enters execute
            wb_valid <= ex_valid;
            if (accept && illegal) begin
                halt <= 1'b1;                   // sticky until reset
            end
        end
    end

    // a live write-back to a real register
    assign wb_rd   = wb_q.rd;
    assign wb_live = wb_valid && (wb_rd != '0);

    // operand match against the write-back stage
    assign fwd_a = (wb_live && wb_rd == dec_q.rs1) ? rv_core_pkg::FWD_WB
                                                   : rv_core_pkg::FWD_RF;
    assign fwd_b = (wb_live && wb_rd == dec_q.rs2) ? rv_core_pkg::FWD_WB
                                                   : rv_core_pkg::FWD_RF;

endmodule

/* src/rv_regfile.sv */
`timescale 1ns/100ps

module rv_regfile #(
    parameter int REG_COUNT = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_isa_pkg::reg_idx_t rs1,
    input  rv_isa_pkg::reg_idx_t rs2,
    output rv_isa_pkg::word_t    rd1,
    output rv_isa_pkg::word_t    rd2,
    input  logic                 we,
    input  rv_core_pkg::wb_t     wr
);

    localparam int IDX_W = $clog2(REG_COUNT);

    rv_isa_pkg::word_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr.rd != '0) begin   // x0 writes dropped
            regs[wr.rd[IDX_W-1:0]] <= wr.data;
        end
    end

    // combinational reads
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1[IDX_W-1:0]];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2[IDX_W-1:0]];

endmodule

/* test/rv_core_tb.sv */
`timescale 1ns/100ps

module rv_core_tb;

    typedef struct packed {
        logic [31:0]          due;      // edge that samples wb_valid high
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::word_t    data;
    } exp_t;

    logic                 clk;
    logic                 rst;
    logic                 instr_valid;
    rv_isa_pkg::word_t    instr;
    logic                 wb_valid;
    rv_isa_pkg::reg_idx_t wb_rd;
    rv_isa_pkg::word_t    wb_data;
    logic                 halt;

    rv_isa_pkg::word_t    model_rf [32];
    exp_t                 exp_q [$];
    logic [31:0]          cyc = 0;          // rising edges so far
    logic [31:0]          halt_edge = 0;    // first edge that sees halt, 0 when none
    logic                 model_halt = 1'b0;
    logic                 exp_valid = 1'b0;
    rv_isa_pkg::reg_idx_t exp_rd = '0;
    rv_isa_pkg::word_t    exp_data = '0;
    logic                 exp_halt = 1'b0;
    int                   issued = 0;
    int                   errors = 0;
    int                   seed = 45047;

    rv_core #(.REG_COUNT(32)) dut_i (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .halt(halt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // expected outputs for the next edge
    always @(posedge clk) begin
        cyc = cyc + 1;
        while (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
            exp_q.delete(0);                    // already checked
        end
        exp_valid = (exp_q.size() != 0 && exp_q[0].due == cyc + 1);
        if (exp_valid) begin
            exp_rd   = exp_q[0].rd;
            exp_data = exp_q[0].data;
        end
        exp_halt = (halt_edge != 0 && cyc + 1 >= halt_edge);
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("ERR %s expected %h actual %h", name, exp, act);
        $display("*** TEST FAILED ***");
        $fatal(1, "mismatch on %s", name);
    endtask

    wb_valid_chk: assert property (@(posedge clk) disable iff (!rst) wb_valid == exp_valid)
        else report_mismatch("wb_valid", $sampled(exp_valid), $sampled(wb_valid));
    wb_rd_chk: assert property (@(posedge clk) disable iff (!rst) wb_valid |-> wb_rd == exp_rd)
        else report_mismatch("wb_rd", $sampled(exp_rd), $sampled(wb_rd));
    wb_data_chk: assert property (@(posedge clk) disable iff (!rst)
                                  wb_valid |-> wb_data == exp_data)
        else report_mismatch("wb_data", $sampled(exp_data), $sampled(wb_data));
    halt_chk: assert property (@(posedge clk) disable iff (!rst) halt == exp_halt)
        else report_mismatch("halt", $sampled(exp_halt), $sampled(halt));

    // RV32I integer semantics
    function automatic rv_isa_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
                                                    input rv_isa_pkg::word_t a,
                                                    input rv_isa_pkg::word_t b);
        rv_isa_pkg::word_t r;
        case (f3)
            rv_isa_pkg::F3_ADD:  r = alt ? a - b : a + b;
            rv_isa_pkg::F3_SLL:  r = a << b[4:0];
            rv_isa_pkg::F3_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv_isa_pkg::F3_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            rv_isa_pkg::F3_XOR:  r = a ^ b;
            rv_isa_pkg::F3_SR: begin
                if (alt) r = $signed(a) >>> b[4:0];
                else r = a >> b[4:0];
            end
            rv_isa_pkg::F3_OR:   r = a | b;
            default:             r = a & b;
        endcase
        return r;
    endfunction

    // one strobe at the falling edge, result queued unless halted
    task automatic send(input rv_isa_pkg::word_t ins, input logic legal,
                        input rv_isa_pkg::reg_idx_t rd, input rv_isa_pkg::word_t data);
        exp_t e;
        instr_valid = 1'b1;
        instr       = ins;
        issued++;
        if (!model_halt && legal) begin
            e.due  = cyc + 3;                   // sampled at k, seen at k+2
            e.rd   = rd;
            e.data = data;
            exp_q.push_back(e);
            if (rd != '0) model_rf[rd] = data;
        end else if (!model_halt) begin
            model_halt = 1'b1;
            halt_edge  = cyc + 2;
        end
        @(negedge clk);
        instr_valid = 1'b0;
        instr       = $random(seed);            // junk while idle
    endtask

    task automatic r_op(input logic [2:0] f3, input logic alt, input rv_isa_pkg::reg_idx_t rd,
                        input rv_isa_pkg::reg_idx_t rs1, input rv_isa_pkg::reg_idx_t rs2);
        rv_isa_pkg::word_t ins;
        ins = {alt ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE, rs2, rs1, f3, rd,
               rv_isa_pkg::OP};
        send(ins, 1'b1, rd, alu_model(f3, alt, model_rf[rs1], model_rf[rs2]));
    endtask

    task automatic i_op(input logic [2:0] f3, input rv_isa_pkg::reg_idx_t rd,
                        input rv_isa_pkg::reg_idx_t rs1, input logic [11:0] imm);
        rv_isa_pkg::word_t ins;
        ins = {imm, rs1, f3, rd, rv_isa_pkg::OP_IMM};
        send(ins, 1'b1, rd, alu_model(f3, f3 == rv_isa_pkg::F3_SR && imm[10],
                                      model_rf[rs1], {{20{imm[11]}}, imm}));
    endtask

    task automatic lui_op(input rv_isa_pkg::reg_idx_t rd, input logic [19:0] up);
        send({up, rd, rv_isa_pkg::LUI}, 1'b1, rd, {up, 12'b0});
    endtask

    task automatic load_value(input rv_isa_pkg::reg_idx_t rd, input rv_isa_pkg::word_t value);
        lui_op(rd, value[31:12] + 20'(value[11])); // addi sign extends the low part
        i_op(rv_isa_pkg::F3_ADD, rd, rd, value[11:0]);
    endtask

    task automatic gap(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge clk);
        gap(2);
    endtask

    task automatic apply_reset();
        rst         = 1'b0;
        instr_valid = 1'b0;
        exp_q.delete();
        model_halt  = 1'b0;
        halt_edge   = 0;
        for (int i = 0; i < 32; i++) model_rf[i] = '0;
        repeat (2) @(posedge clk);              // two reset cycles
        @(negedge clk);
        rst = 1'b1;
    endtask

    initial begin
        logic [2:0]           f3;
        logic                 alt;
        rv_isa_pkg::reg_idx_t ra;
        rv_isa_pkg::reg_idx_t rb;
        rv_isa_pkg::reg_idx_t rd;
        instr_valid = 1'b0;
        instr       = '0;
        apply_reset();
        gap(4);                                 // quiet outputs before any strobe
        r_op(rv_isa_pkg::F3_ADD, 1'b0, 5'd3, 5'd1, 5'd2);
        drain();
        for (int i = 1; i <= 7; i++) load_value(5'(i), $random(seed));
        load_value(5'd8, $random(seed) | 32'h8000_0000);
        load_value(5'd9, $random(seed) | 32'h8000_0000);
        for (int i = 0; i < 8; i++) begin
            ra = 5'(1 + {$random(seed)} % 8);
            rb = 5'(1 + {$random(seed)} % 8);
            r_op(3'(i), 1'b0, 5'(10 + i), ra, rb);
        end
        r_op(rv_isa_pkg::F3_ADD, 1'b1, 5'd18, 5'd1, 5'd2);    // sub
        r_op(rv_isa_pkg::F3_SR, 1'b1, 5'd19, 5'd8, 5'd3);     // sra on negative
        i_op(rv_isa_pkg::F3_ADD, 5'd16, 5'd9, 12'hF85);
        i_op(rv_isa_pkg::F3_SLT, 5'd17, 5'd1, 12'h800);
        i_op(rv_isa_pkg::F3_SLT, 5'd18, 5'd9, 12'hFFF);
        i_op(rv_isa_pkg::F3_XOR, 5'd19, 5'd2, 12'($random(seed)));
        i_op(rv_isa_pkg::F3_OR, 5'd20, 5'd3, 12'($random(seed)));
        i_op(rv_isa_pkg::F3_AND, 5'd21, 5'd4, 12'($random(seed)));
        i_op(rv_isa_pkg::F3_SLL, 5'd22, 5'd5, {7'b0, 5'd13});
        i_op(rv_isa_pkg::F3_SR, 5'd23, 5'd9, {7'b0, 5'd7});           // srli
        i_op(rv_isa_pkg::F3_SR, 5'd24, 5'd9, {7'b0100000, 5'd7});     // srai
        i_op(rv_isa_pkg::F3_SR, 5'd25, 5'd8, {7'b0100000, 5'd31});
        drain();
        i_op(rv_isa_pkg::F3_ADD, 5'd5, 5'd0, 12'd7);
        r_op(rv_isa_pkg::F3_ADD, 1'b0, 5'd6, 5'd5, 5'd5);     // both operands forwarded
        r_op(rv_isa_pkg::F3_ADD, 1'b1, 5'd7, 5'd6, 5'd5);
        gap(1);
        r_op(rv_isa_pkg::F3_XOR, 1'b0, 5'd8, 5'd7, 5'd6);     // register file path
        gap(2);
        r_op(rv_isa_pkg::F3_OR, 1'b0, 5'd9, 5'd8, 5'd7);
        i_op(rv_isa_pkg::F3_ADD, 5'd0, 5'd9, 12'd99);         // x0 stays zero
        r_op(rv_isa_pkg::F3_ADD, 1'b0, 5'd10, 5'd0, 5'd9);
        gap(1);
        r_op(rv_isa_pkg::F3_ADD, 1'b0, 5'd11, 5'd9, 5'd0);
        for (int n = 0; n < 40; n++) begin   // dense chains over x0..x7
            f3  = 3'($random(seed));
            alt = 1'($random(seed)) && (f3 == rv_isa_pkg::F3_ADD || f3 == rv_isa_pkg::F3_SR);
            ra  = 5'({$random(seed)} % 8);
            rb  = 5'({$random(seed)} % 8);
            rd  = 5'({$random(seed)} % 8);
            r_op(f3, alt, rd, ra, rb);
            gap({$random(seed)} % 3);
        end
        drain();
        r_op(rv_isa_pkg::F3_ADD, 1'b0, 5'd12, 5'd1, 5'd2);
        r_op(rv_isa_pkg::F3_AND, 1'b0, 5'd13, 5'd12, 5'd3);
        send({7'b0000001, 5'd2, 5'd1, rv_isa_pkg::F3_ADD, 5'd14, rv_isa_pkg::OP}, 1'b0, '0, '0);
        r_op(rv_isa_pkg::F3_ADD, 1'b0, 5'd15, 5'd1, 5'd2);    // dropped while halted
        gap(6);
        drain();
        apply_reset();
        r_op(rv_isa_pkg::F3_ADD, 1'b0, 5'd3, 5'd1, 5'd2);
        send({12'd5, 5'd1, rv_isa_pkg::F3_SLTU, 5'd4, rv_isa_pkg::OP_IMM}, 1'b0, '0, '0);
        i_op(rv_isa_pkg::F3_ADD, 5'd4, 5'd1, 12'd1);
        drain();
        apply_reset();
        load_value(5'd1, $random(seed));
        r_op(rv_isa_pkg::F3_SLTU, 1'b0, 5'd2, 5'd0, 5'd1);
        r_op(rv_isa_pkg::F3_ADD, 1'b0, 5'd3, 5'd2, 5'd4);
        drain();
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // run limit grows with the number of strobes
    initial begin
        int ticks;
        ticks = 0;
        while (ticks <= 20 * issued + 100) begin
            @(posedge clk);
            ticks++;
        end
        $display("timeout: run went past %0d cycles for %0d instructions", ticks - 1, issued);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule
